// File: Makefile
SOURCES := $(shell grep -v '^+' build.f) include/sensor_script.svh

run: obj_dir/Vtb_camera_config
	./obj_dir/Vtb_camera_config

obj_dir/Vtb_camera_config: build.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_camera_config -o Vtb_camera_config

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: build.f
+incdir+include
source/camera_config_pkg.sv
source/script_decoder.sv
source/i2c_engine.sv
source/id_probe.sv
source/camera_config_top.sv
tests/i2c_sensor_model.sv
tests/tb_camera_config.sv

// File: include/sensor_script.svh
localparam camera_config_pkg::scriptEntry_t SENSOR_SCRIPT [0:23] = '{
   '{camera_config_pkg::SENSOR_ADDR, 16'h0103, 8'h01},  // software reset
   '{camera_config_pkg::SENSOR_ADDR, 16'h0103, 8'h01},  // repeated, as on the board
   '{camera_config_pkg::DELAY_TAG,   16'h0000, 8'd10},  // let reset settle
   '{camera_config_pkg::SENSOR_ADDR, 16'h0100, 8'h00},  // software standby
   '{camera_config_pkg::SENSOR_ADDR, 16'h0100, 8'h00},
   '{camera_config_pkg::DELAY_TAG,   16'h0000, 8'd10},
   '{camera_config_pkg::SENSOR_ADDR, 16'h0302, 8'd24},  // pll1 multiplier
   '{camera_config_pkg::SENSOR_ADDR, 16'h0303, 8'h00},  // pll1 divm
   '{camera_config_pkg::SENSOR_ADDR, 16'h0304, 8'd3},   // pll1 mipi divider
   '{camera_config_pkg::SENSOR_ADDR, 16'h030E, 8'h00},  // pll2 r_divs
   '{camera_config_pkg::SENSOR_ADDR, 16'h030F, 8'h04},  // pll2 r_divsp
   '{camera_config_pkg::SENSOR_ADDR, 16'h0312, 8'h01},  // pll2 pre-divider
   '{camera_config_pkg::SENSOR_ADDR, 16'h031E, 8'h0C},
   '{camera_config_pkg::SENSOR_ADDR, 16'h3018, 8'h72},  // mipi 4 lane
   '{camera_config_pkg::SENSOR_ADDR, 16'h3808, 8'h02},  // x output size 640
   '{camera_config_pkg::SENSOR_ADDR, 16'h3809, 8'h80},
   '{camera_config_pkg::SENSOR_ADDR, 16'h380A, 8'h01},  // y output size 480
   '{camera_config_pkg::SENSOR_ADDR, 16'h380B, 8'hE0},
   '{camera_config_pkg::SENSOR_ADDR, 16'h380C, 8'h12},  // hts
   '{camera_config_pkg::SENSOR_ADDR, 16'h380D, 8'h00},
   '{camera_config_pkg::SENSOR_ADDR, 16'h380E, 8'h02},  // vts
   '{camera_config_pkg::SENSOR_ADDR, 16'h380F, 8'h1E},
   '{camera_config_pkg::DELAY_TAG,   16'h0000, 8'd10},
   '{camera_config_pkg::SENSOR_ADDR, 16'h0100, 8'h01}   // wake up, streaming
};

// File: source/camera_config_pkg.sv
`default_nettype none

package camera_config_pkg;

   // transfer kinds handled by the single I2C engine
   typedef enum logic [1:0] {
      XFER_POINTER = 2'd0,  // address + 2 pointer bytes
      XFER_WRITE   = 2'd1,  // address + 2 pointer bytes + 1 data byte
      XFER_READ    = 2'd2   // address with R bit + 1 byte, master NACK
   } xferKind_t;

   // one bus transfer as handed from the decoder to the engine
   typedef struct packed {
      xferKind_t   kind;
      logic [7:0]  slaveAddr;  // 7-bit address plus R/W bit
      logic [15:0] regAddr;
      logic [7:0]  data;
   } i2cRequest_t;

   // one line of the register script
   typedef struct packed {
      logic [7:0]  slaveOrTag;  // slave write address or DELAY_TAG
      logic [15:0] regAddr;
      logic [7:0]  data;        // write data, or delay count for a tag
   } scriptEntry_t;

   localparam logic [7:0]  SENSOR_ADDR = 8'h6C;    // 8-bit write address
   localparam logic [15:0] ID_REGISTER = 16'h300B; // chip-ID high byte
   localparam logic [7:0]  DELAY_TAG   = 8'hAA;    // marks a delay entry

endpackage

`default_nettype wire

// File: source/camera_config_top.sv
`timescale 1ns/1ps
`default_nettype none

module camera_config_top #(
   parameter int         SCRIPT_LENGTH = 24,
   parameter int         DELAY_UNIT    = 64,     // CLK_400K cycles per delay count
   parameter logic [7:0] EXPECTED_ID   = 8'h88
) (
   input  logic       CLK_400K,
   input  logic       RESET_N,
   input  logic       sdaIn,
   output logic       i2cScl,
   output logic       sdaDriveLow,
   output logic       configDone,
   output logic [7:0] sensorId,
   output logic [7:0] probeFailCount
);
   import camera_config_pkg::*;

   i2cRequest_t request;
   logic        requestStrobe;
   logic        doneStrobe;
   logic [7:0]  readData;
   logic        probeReadStrobe;
   logic        probeResult;
   logic        probeMatch;

   script_decoder #(
      .SCRIPT_LENGTH (SCRIPT_LENGTH),
      .DELAY_UNIT    (DELAY_UNIT)
   ) script_decoder_i (
      .CLK_400K        (CLK_400K),
      .RESET_N         (RESET_N),
      .doneStrobe      (doneStrobe),
      .probeResult     (probeResult),
      .probeMatch      (probeMatch),
      .request         (request),
      .requestStrobe   (requestStrobe),
      .probeReadStrobe (probeReadStrobe),
      .configDone      (configDone)
   );

   i2c_engine i2c_engine_i (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .request       (request),
      .requestStrobe (requestStrobe),
      .sdaIn         (sdaIn),
      .i2cScl        (i2cScl),
      .sdaDriveLow   (sdaDriveLow),
      .doneStrobe    (doneStrobe),
      .readData      (readData)
   );

   id_probe #(
      .EXPECTED_ID (EXPECTED_ID)
   ) id_probe_i (
      .CLK_400K        (CLK_400K),
      .RESET_N         (RESET_N),
      .doneStrobe      (doneStrobe),
      .readData        (readData),
      .probeReadStrobe (probeReadStrobe),
      .probeResult     (probeResult),
      .probeMatch      (probeMatch),
      .sensorId        (sensorId),
      .probeFailCount  (probeFailCount)
   );

endmodule

`default_nettype wire

// File: source/i2c_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_engine (
   input  logic                          CLK_400K,
   input  logic                          RESET_N,
   input  camera_config_pkg::i2cRequest_t request,
   input  logic                          requestStrobe,
   input  logic                          sdaIn,
   output logic                          i2cScl,
   output logic                          sdaDriveLow,
   output logic                          doneStrobe,
   output logic [7:0]                    readData
);
   import camera_config_pkg::*;

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_START,
      BUS_BITS,
      BUS_STOP
   } busState_t;

   busState_t   busState;
   logic [1:0]  phase;      // quarter of the current SCL period
   logic [3:0]  bitIndex;   // 8 is the ACK slot
   logic [1:0]  byteIndex;
   logic [1:0]  lastByte;
   logic        isRead;
   logic [31:0] txShift;    // address, pointer, data, MSB first
   logic [7:0]  rxShift;    // data bits of the current byte
   logic        masterDrives;
   logic        sdaLevel;

   // master lets go of SDA in ACK slots and in the byte the sensor returns
   assign masterDrives = (bitIndex != 4'd8) && !(isRead && byteIndex == 2'd1);

   always_comb begin
      case (busState)
         BUS_START: begin
            i2cScl   = (phase != 2'd3);
            sdaLevel = (phase == 2'd0);  // falls while SCL is high
         end
         BUS_BITS: begin
            i2cScl   = (phase == 2'd1) || (phase == 2'd2);
            sdaLevel = masterDrives ? txShift[31] : 1'b1;
         end
         BUS_STOP: begin
            i2cScl   = (phase != 2'd0);
            sdaLevel = (phase[1] == 1'b1);  // rises while SCL is high
         end
         default: begin
            i2cScl   = 1'b1;
            sdaLevel = 1'b1;
         end
      endcase
   end

   assign sdaDriveLow = !sdaLevel;
   assign readData    = rxShift;  // byte last shifted in

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         busState   <= BUS_IDLE;
         phase      <= 2'd0;
         bitIndex   <= 4'd0;
         byteIndex  <= 2'd0;
         doneStrobe <= 1'b0;
      end else begin
         doneStrobe <= (busState == BUS_STOP) && (phase == 2'd2);
         if (busState == BUS_IDLE) begin
            phase <= 2'd0;
            if (requestStrobe) begin
               busState <= BUS_START;
            end
         end else begin
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
               case (busState)
                  BUS_START: begin
                     busState  <= BUS_BITS;
                     bitIndex  <= 4'd0;
                     byteIndex <= 2'd0;
                  end
                  BUS_BITS: begin
                     if (bitIndex != 4'd8) begin
                        bitIndex <= bitIndex + 4'd1;
                     end else begin
                        bitIndex <= 4'd0;
                        if (byteIndex == lastByte) begin
                           busState <= BUS_STOP;
                        end else begin
                           byteIndex <= byteIndex + 2'd1;
                        end
                     end
                  end
                  default: begin
                     busState <= BUS_IDLE;  // stop period over
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (busState == BUS_IDLE && requestStrobe) begin
         txShift <= {request.slaveAddr, request.regAddr, request.data};
         isRead  <= (request.kind == XFER_READ);
         case (request.kind)
            XFER_POINTER: lastByte <= 2'd2;
            XFER_WRITE:   lastByte <= 2'd3;
            default:      lastByte <= 2'd1;
         endcase
      end else if (busState == BUS_BITS) begin
         if (phase == 2'd2 && bitIndex != 4'd8) begin
            rxShift <= {rxShift[6:0], sdaIn};  // sample mid high phase
         end
         if (phase == 2'd3 && bitIndex != 4'd8) begin
            txShift <= {txShift[30:0], 1'b0};
         end
      end
   end

   noRequestWhileBusy: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      requestStrobe |-> busState == BUS_IDLE);

   // SDA may move under a high SCL only for start and stop
   sdaStableWhileSclHigh: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      ($changed(sdaDriveLow) && i2cScl && $past(i2cScl))
         |-> (busState == BUS_START || busState == BUS_STOP));

endmodule

`default_nettype wire

// File: source/id_probe.sv
`timescale 1ns/1ps
`default_nettype none

module id_probe #(
   parameter logic [7:0] EXPECTED_ID = 8'h88
) (
   input  logic       CLK_400K,
   input  logic       RESET_N,
   input  logic       doneStrobe,
   input  logic [7:0] readData,
   input  logic       probeReadStrobe,
   output logic       probeResult,
   output logic       probeMatch,
   output logic [7:0] sensorId,
   output logic [7:0] probeFailCount
);

   // read of address plus one byte is 80 cycles, the result follows a cycle later
   localparam int READ_TO_RESULT = 4 * (9 * 2 + 2) + 1;

   logic readPending;  // flagged ID read on the bus
   logic idDone;
   logic idMatch;

   assign idDone  = readPending && doneStrobe;
   assign idMatch = (readData == EXPECTED_ID);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         readPending    <= 1'b0;
         probeResult    <= 1'b0;
         probeFailCount <= 8'd0;
      end else begin
         probeResult <= idDone;
         if (probeReadStrobe) begin
            readPending <= 1'b1;
         end else if (doneStrobe) begin
            readPending <= 1'b0;
         end
         if (idDone && !idMatch && probeFailCount != 8'hFF) begin
            probeFailCount <= probeFailCount + 8'd1;  // saturates at 255
         end
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (idDone) begin
         sensorId   <= readData;
         probeMatch <= idMatch;
      end
   end

   resultFollowsIdRead: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      probeResult |-> $past(probeReadStrobe, READ_TO_RESULT));

endmodule

`default_nettype wire

// File: source/script_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module script_decoder #(
   parameter int SCRIPT_LENGTH = 24,
   parameter int DELAY_UNIT    = 64
) (
   input  logic                           CLK_400K,
   input  logic                           RESET_N,
   input  logic                           doneStrobe,
   input  logic                           probeResult,
   input  logic                           probeMatch,
   output camera_config_pkg::i2cRequest_t request,
   output logic                           requestStrobe,
   output logic                           probeReadStrobe,
   output logic                           configDone
);
   import camera_config_pkg::*;

   `include "sensor_script.svh"

   localparam int INDEX_WIDTH = $clog2(SCRIPT_LENGTH + 1);
   localparam int WAIT_WIDTH  = $clog2(256 * DELAY_UNIT);

   localparam logic [WAIT_WIDTH-1:0]  GAP_COUNT    = WAIT_WIDTH'(2);  // strobe 4 cycles after done
   localparam logic [WAIT_WIDTH-1:0]  RESULT_GAP   = WAIT_WIDTH'(1);  // result is a cycle late
   localparam logic [WAIT_WIDTH-1:0]  RETRY_COUNT  = WAIT_WIDTH'(4 * DELAY_UNIT);
   localparam logic [INDEX_WIDTH-1:0] LAST_INDEX   = INDEX_WIDTH'(SCRIPT_LENGTH - 1);

   typedef enum logic [2:0] {
      PTR_GAP,
      PTR_BUSY,
      READ_GAP,
      READ_BUSY,
      ENTRY_GAP,
      WRITE_BUSY,
      DELAY_WAIT,
      CONFIG_IDLE
   } decodeState_t;

   decodeState_t           decodeState;
   logic [WAIT_WIDTH-1:0]  waitCount;
   logic [INDEX_WIDTH-1:0] entryIndex;
   scriptEntry_t           currentEntry;

   assign currentEntry = SENSOR_SCRIPT[entryIndex];

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         decodeState     <= PTR_GAP;
         waitCount       <= '0;
         entryIndex      <= '0;
         requestStrobe   <= 1'b0;
         probeReadStrobe <= 1'b0;
         configDone      <= 1'b0;
      end else begin
         requestStrobe   <= 1'b0;
         probeReadStrobe <= 1'b0;
         case (decodeState)
            PTR_GAP: begin
               if (waitCount != '0) begin
                  waitCount <= waitCount - WAIT_WIDTH'(1);
               end else begin
                  requestStrobe <= 1'b1;  // set ID pointer
                  decodeState   <= PTR_BUSY;
               end
            end
            PTR_BUSY: begin
               if (doneStrobe) begin
                  waitCount   <= GAP_COUNT;
                  decodeState <= READ_GAP;
               end
            end
            READ_GAP: begin
               if (waitCount != '0) begin
                  waitCount <= waitCount - WAIT_WIDTH'(1);
               end else begin
                  requestStrobe   <= 1'b1;
                  probeReadStrobe <= 1'b1;  // tell id_probe this read is the ID
                  decodeState     <= READ_BUSY;
               end
            end
            READ_BUSY: begin
               if (probeResult) begin
                  if (probeMatch) begin
                     waitCount   <= GAP_COUNT - RESULT_GAP;
                     decodeState <= ENTRY_GAP;
                  end else begin
                     waitCount   <= RETRY_COUNT;  // back off, then probe again
                     decodeState <= PTR_GAP;
                  end
               end
            end
            ENTRY_GAP: begin
               if (waitCount != '0) begin
                  waitCount <= waitCount - WAIT_WIDTH'(1);
               end else if (currentEntry.slaveOrTag == DELAY_TAG) begin
                  waitCount   <= WAIT_WIDTH'(currentEntry.data * DELAY_UNIT);
                  decodeState <= DELAY_WAIT;
               end else begin
                  requestStrobe <= 1'b1;
                  decodeState   <= WRITE_BUSY;
               end
            end
            WRITE_BUSY: begin
               if (doneStrobe) begin
                  if (entryIndex == LAST_INDEX) begin
                     configDone  <= 1'b1;
                     decodeState <= CONFIG_IDLE;
                  end else begin
                     entryIndex  <= entryIndex + 1'b1;
                     waitCount   <= GAP_COUNT;
                     decodeState <= ENTRY_GAP;
                  end
               end
            end
            DELAY_WAIT: begin
               if (waitCount != '0) begin
                  waitCount <= waitCount - WAIT_WIDTH'(1);  // no bus traffic here
               end else if (entryIndex == LAST_INDEX) begin
                  configDone  <= 1'b1;
                  decodeState <= CONFIG_IDLE;
               end else begin
                  entryIndex  <= entryIndex + 1'b1;
                  decodeState <= ENTRY_GAP;
               end
            end
            default: begin
               decodeState <= CONFIG_IDLE;  // script finished, stay here
            end
         endcase
      end
   end

   // request payload follows the state, engine takes it with the strobe
   always_ff @(posedge CLK_400K) begin
      case (decodeState)
         PTR_GAP:   request <= '{XFER_POINTER, SENSOR_ADDR, ID_REGISTER, 8'h00};
         READ_GAP:  request <= '{XFER_READ, {SENSOR_ADDR[7:1], 1'b1}, ID_REGISTER, 8'h00};
         ENTRY_GAP: request <= '{XFER_WRITE, currentEntry.slaveOrTag, currentEntry.regAddr,
                                 currentEntry.data};
         default:   request <= request;
      endcase
   end

   entryInRange: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      entryIndex < SCRIPT_LENGTH);

endmodule

`default_nettype wire

// File: tests/i2c_sensor_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sensor_model #(
   parameter logic [7:0] EXPECTED_ID = 8'h88
) (
   input  logic                            CLK_400K,
   input  logic                            RESET_N,
   input  logic                            scl,
   input  logic                            sda,            // resolved wired-AND line
   input  logic [7:0]                      wrongIdCount,   // wrong IDs before the right one
   output logic                            sdaDriveLow,
   output logic                            startStrobe,
   output logic                            stopStrobe,
   output logic                            writeStrobe,
   output camera_config_pkg::scriptEntry_t recordedWrite,
   output logic [7:0]                      idReadCount,
   output logic                            protocolError
);
   import camera_config_pkg::*;

   logic       prevScl;
   logic       prevSda;
   logic       busy;
   logic       reading;
   logic [3:0] bitCount;   // SCL rises seen in the current byte
   logic [2:0] byteCount;
   logic [7:0] shiftIn;
   logic [7:0] shiftOut;
   logic [7:0] idValue;
   logic [7:0] rxBytes [0:3];

   assign idValue = (idReadCount < wrongIdCount) ? ~EXPECTED_ID : EXPECTED_ID;

   // both lines are sampled mid cycle, away from the master's edges
   always @(negedge CLK_400K) begin
      if (!RESET_N) begin
         sdaDriveLow   <= 1'b0;
         startStrobe   <= 1'b0;
         stopStrobe    <= 1'b0;
         writeStrobe   <= 1'b0;
         recordedWrite <= '0;
         idReadCount   <= 8'd0;
         protocolError <= 1'b0;
         prevScl       <= 1'b1;
         prevSda       <= 1'b1;
         busy          <= 1'b0;
         reading       <= 1'b0;
         bitCount      <= 4'd0;
         byteCount     <= 3'd0;
      end else begin
         startStrobe <= 1'b0;
         stopStrobe  <= 1'b0;
         writeStrobe <= 1'b0;
         prevScl     <= scl;
         prevSda     <= sda;
         if (scl && prevScl && sda != prevSda) begin
            if (!sda && !busy) begin
               busy        <= 1'b1;  // start condition
               reading     <= 1'b0;
               bitCount    <= 4'd0;
               byteCount   <= 3'd0;
               startStrobe <= 1'b1;
            end else if (sda && busy && bitCount == 4'd1) begin
               busy        <= 1'b0;  // stop condition
               stopStrobe  <= 1'b1;
               sdaDriveLow <= 1'b0;
               if (!reading && byteCount == 3'd4) begin
                  writeStrobe   <= 1'b1;
                  recordedWrite <= '{rxBytes[0], {rxBytes[1], rxBytes[2]}, rxBytes[3]};
               end
            end else begin
               protocolError <= 1'b1;
               $display("I2C protocol error at %0t: SDA changed while SCL was high %s",
                        $time, "outside a start or stop condition");
            end
         end else if (busy && scl && !prevScl) begin
            shiftIn  <= {shiftIn[6:0], sda};  // byte is taken before the ACK slot shifts in
            bitCount <= bitCount + 4'd1;
         end else if (busy && !scl && prevScl) begin
            if (bitCount == 4'd8) begin
               if (byteCount < 3'd4) begin
                  rxBytes[byteCount[1:0]] <= shiftIn;
               end
               if (byteCount == 3'd0) begin
                  reading <= shiftIn[0];  // R/W bit
               end
               sdaDriveLow <= !(reading && byteCount == 3'd1);  // master NACKs our byte
            end else if (bitCount == 4'd9) begin
               bitCount  <= 4'd0;
               byteCount <= byteCount + 3'd1;
               if (byteCount == 3'd0 && reading) begin
                  shiftOut    <= idValue;
                  sdaDriveLow <= !idValue[7];
                  idReadCount <= idReadCount + 8'd1;
               end else begin
                  sdaDriveLow <= 1'b0;
               end
            end else if (reading && byteCount == 3'd1 && bitCount != 4'd0) begin
               sdaDriveLow <= !shiftOut[6];  // next ID bit, MSB first
               shiftOut    <= {shiftOut[6:0], 1'b0};
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_camera_config.sv
`timescale 1ns/1ps
`default_nettype none

module tb_camera_config;
   import camera_config_pkg::*;

   `include "sensor_script.svh"

   localparam int         SCRIPT_LENGTH = 24;
   localparam int         DELAY_UNIT    = 64;
   localparam logic [7:0] EXPECTED_ID   = 8'h88;
   localparam int         PROBE_CYCLES  = 116 + 80 + 8 + 4 * DELAY_UNIT;
   localparam int         WRITE_CYCLES  = 156;
   localparam int         QUIET_CYCLES  = 200;  // watched for stray starts after done

   logic         CLK_400K;
   logic         RESET_N;
   logic         i2cScl;
   logic         dutSdaLow;
   logic         modelSdaLow;
   logic         sdaLine;
   logic         configDone;
   logic [7:0]   sensorId;
   logic [7:0]   probeFailCount;
   logic         startStrobe;
   logic         stopStrobe;
   logic         writeStrobe;
   logic         protocolError;
   logic [7:0]   idReadCount;
   scriptEntry_t recordedWrite;
   logic [7:0]   wrongIds;
   logic [31:0]  lfsrState;
   logic         doneSeen = 1'b0;
   int           cycleCount = 0;
   int           timeoutLimit = 0;
   int           writesSeen = 0;
   int           lastStartCycle = 0;
   int           prevStopCycle = 0;
   int           lastStopCycle = 0;
   scriptEntry_t expectedWrites [$];
   int           expectedIdle [$];

   // open-drain line with pull-up
   assign sdaLine = !(dutSdaLow === 1'b1 || modelSdaLow === 1'b1);

   camera_config_top #(
      .SCRIPT_LENGTH (SCRIPT_LENGTH),
      .DELAY_UNIT    (DELAY_UNIT),
      .EXPECTED_ID   (EXPECTED_ID)
   ) camera_config_top_i (
      .CLK_400K       (CLK_400K),
      .RESET_N        (RESET_N),
      .sdaIn          (sdaLine),
      .i2cScl         (i2cScl),
      .sdaDriveLow    (dutSdaLow),
      .configDone     (configDone),
      .sensorId       (sensorId),
      .probeFailCount (probeFailCount)
   );

   i2c_sensor_model #(
      .EXPECTED_ID (EXPECTED_ID)
   ) i2c_sensor_model_i (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .scl           (i2cScl),
      .sda           (sdaLine),
      .wrongIdCount  (wrongIds),
      .sdaDriveLow   (modelSdaLow),
      .startStrobe   (startStrobe),
      .stopStrobe    (stopStrobe),
      .writeStrobe   (writeStrobe),
      .recordedWrite (recordedWrite),
      .idReadCount   (idReadCount),
      .protocolError (protocolError)
   );

   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // x^32+x^22+x^2+x+1
   endfunction

   // expected bus writes, each with the idle time that must come before it
   function automatic void buildReference();
      int pendingIdle;
      pendingIdle = 0;
      for (int i = 0; i < SCRIPT_LENGTH; i++) begin
         if (SENSOR_SCRIPT[i].slaveOrTag == DELAY_TAG) begin
            pendingIdle += SENSOR_SCRIPT[i].data * DELAY_UNIT;
         end else begin
            expectedWrites.push_back(SENSOR_SCRIPT[i]);
            expectedIdle.push_back(pendingIdle);
            pendingIdle = 0;
         end
      end
   endfunction

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compareValues(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
      if (actual !== expected) begin
         failRun($sformatf("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                           $time, what, actual, expected));
      end
   endtask

   initial begin
      CLK_400K = 1'b0;
      forever #20 CLK_400K = ~CLK_400K;
   end

   // model events are sampled at the rising edge, half a cycle after they change
   always @(posedge CLK_400K) begin
      cycleCount++;
      if (cycleCount > timeoutLimit) begin
         failRun($sformatf("timeout, configuration not finished after %0d cycles",
                           timeoutLimit));
      end
      if (protocolError === 1'b1) begin
         failRun("the sensor model saw an I2C protocol violation on the bus");
      end
      if (startStrobe === 1'b1) begin
         compareValues(doneSeen, 1'b0, "start condition after configDone");
         prevStopCycle  = lastStopCycle;
         lastStartCycle = cycleCount;
      end
      if (writeStrobe === 1'b1) begin
         compareValues(writesSeen < expectedWrites.size(), 1, "more writes than the script holds");
         compareValues(idReadCount, wrongIds + 8'd1, "ID reads before a register write");
         compareValues(recordedWrite.slaveOrTag, SENSOR_ADDR, "write slave address");
         compareValues(recordedWrite.regAddr, expectedWrites[writesSeen].regAddr,
                       $sformatf("register of write %0d", writesSeen));
         compareValues(recordedWrite.data, expectedWrites[writesSeen].data,
                       $sformatf("data of write %0d", writesSeen));
         compareValues(lastStartCycle - prevStopCycle >= expectedIdle[writesSeen], 1,
                       $sformatf("idle time before write %0d", writesSeen));
         writesSeen++;
      end
      if (stopStrobe === 1'b1) begin
         lastStopCycle = cycleCount;
      end
   end

   // configDone moves on the rising edge, so it is watched on the falling one
   always @(negedge CLK_400K) begin
      if (configDone === 1'b1) begin
         if (!doneSeen) begin
            compareValues(writesSeen, expectedWrites.size(), "writes done when configDone rose");
            compareValues(cycleCount - lastStopCycle <= 2, 1, "configDone follows the last write");
         end
         doneSeen = 1'b1;
      end else if (doneSeen) begin
         failRun("configDone fell after the configuration had finished");
      end
   end

   initial begin
      int delayCycles;
      delayCycles = 0;
      RESET_N     = 1'b0;
      lfsrState   = 32'he267;
      wrongIds    = 8'd0;
      while (wrongIds == 8'd0) begin  // two bits per draw, zero is drawn again
         repeat (2) begin
            lfsrState = lfsrNext(lfsrState);
            wrongIds  = {wrongIds[6:0], lfsrState[0]};
         end
      end
      buildReference();
      for (int i = 0; i < SCRIPT_LENGTH; i++) begin
         if (SENSOR_SCRIPT[i].slaveOrTag == DELAY_TAG) begin
            delayCycles += SENSOR_SCRIPT[i].data * DELAY_UNIT;
         end
      end
      timeoutLimit = 2 * ((wrongIds + 1) * PROBE_CYCLES
                          + expectedWrites.size() * WRITE_CYCLES + delayCycles);
      repeat (2) @(negedge CLK_400K);
      RESET_N = 1'b1;
      while (configDone !== 1'b1) begin
         @(negedge CLK_400K);
      end
      repeat (QUIET_CYCLES) @(negedge CLK_400K);
      compareValues(configDone, 1'b1, "configDone after the script");
      compareValues(writesSeen, expectedWrites.size(), "number of register writes");
      compareValues(probeFailCount, wrongIds, "failed probe count");
      compareValues(sensorId, EXPECTED_ID, "sensor ID");
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
